// ==== hw/csr_pkg.sv ====
package csr_pkg;

	// Data path and host address widths
	localparam int unsigned data_w = 32;
	localparam int unsigned idx_w = 6;
	localparam int unsigned axil_addr_w = 8;

	// Register index map
	// Indices 0x00 to 0x1f are the general registers, r0 reads as zero
	localparam logic [idx_w-1:0] csr_mip = 6'h21;
	localparam logic [idx_w-1:0] csr_mstatus = 6'h30;
	localparam logic [idx_w-1:0] csr_mie = 6'h31;
	localparam logic [idx_w-1:0] csr_mtvec = 6'h32;

	// Data-execution-protection window bounds
	localparam logic [idx_w-1:0] csr_dep_lo = 6'h33;
	localparam logic [idx_w-1:0] csr_dep_hi = 6'h34;

	// 64-bit counters, low half first
	localparam logic [idx_w-1:0] csr_mcycle = 6'h38;
	localparam logic [idx_w-1:0] csr_mcycleh = 6'h39;
	localparam logic [idx_w-1:0] csr_minstret = 6'h3a;
	localparam logic [idx_w-1:0] csr_minstreth = 6'h3b;

	// Write strobe for the core soft reset
	localparam logic [idx_w-1:0] csr_soft_reset = 6'h3f;

	// Upper index bits of the read-only block 0x20 to 0x27
	localparam logic [2:0] ro_window = 3'b100;

	// AXI response codes
	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// Feature defaults for the register file
	localparam bit enable_dep_default = 1'b1;
	localparam bit enable_counters_default = 1'b1;

endpackage

// ==== hw/reg_access_if.sv ====
`timescale 1ns/100ps

interface reg_access_if;
	import csr_pkg::*;

	// Access request, held by the issuer until done
	logic valid;
	logic write;
	logic [idx_w-1:0] idx;
	logic [data_w-1:0] wdata;

	// One-cycle completion pulse from the register file
	logic done;

	// Front end side
	modport issuer (
		output valid,
		output write,
		output idx,
		output wdata,
		input done
	);

	// Register file side
	modport executor (
		input valid,
		input write,
		input idx,
		input wdata,
		output done
	);

endinterface

// ==== hw/axil_reg_frontend.sv ====
`timescale 1ns/100ps

module axil_reg_frontend (
	input logic clock,
	input logic reset,

	// Write address channel
	input logic s_axil_awvalid,
	output logic s_axil_awready,
	input logic [csr_pkg::axil_addr_w-1:0] s_axil_awaddr,

	// Write data channel
	input logic s_axil_wvalid,
	output logic s_axil_wready,
	input logic [csr_pkg::data_w-1:0] s_axil_wdata,

	// Read address channel
	input logic s_axil_arvalid,
	output logic s_axil_arready,
	input logic [csr_pkg::axil_addr_w-1:0] s_axil_araddr,

	// High while the response channel holds nothing
	input logic idle,

	reg_access_if.issuer acc
);
	import csr_pkg::*;

	// Holding flags, one per AXI address or data channel
	logic aw_held;
	logic w_held;
	logic ar_held;

	// Held payloads, byte address already reduced to a register index
	logic [idx_w-1:0] aw_idx;
	logic [idx_w-1:0] ar_idx;
	logic [data_w-1:0] w_data;

	// Channel handshakes
	logic aw_fire;
	logic w_fire;
	logic ar_fire;

	logic wr_pending;
	logic rd_pending;
	logic issue;
	logic retire;

	// Accept new requests only while the response buffer is empty
	assign s_axil_awready = idle && !aw_held;
	assign s_axil_wready = idle && !w_held;
	assign s_axil_arready = idle && !ar_held;

	assign aw_fire = s_axil_awvalid && s_axil_awready;
	assign w_fire = s_axil_wvalid && s_axil_wready;
	assign ar_fire = s_axil_arvalid && s_axil_arready;

	// A write needs both halves before it can go out
	assign wr_pending = aw_held && w_held;
	assign rd_pending = ar_held;

	// One access in flight, and never while a response is still held
	assign issue = !acc.valid && idle && (wr_pending || rd_pending);
	assign retire = acc.valid && acc.done;

	always_ff @(posedge clock) begin
		if (reset) begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
			ar_held <= 1'b0;
			acc.valid <= 1'b0;
		end else begin
			if (aw_fire) begin
				aw_held <= 1'b1;
			end
			if (w_fire) begin
				w_held <= 1'b1;
			end
			if (ar_fire) begin
				ar_held <= 1'b1;
			end

			// Request stays up until the register file pulses done
			if (issue) begin
				acc.valid <= 1'b1;
			end else if (retire) begin
				acc.valid <= 1'b0;
			end

			// Free the holding registers of the access that just finished
			if (retire) begin
				if (acc.write) begin
					aw_held <= 1'b0;
					w_held <= 1'b0;
				end else begin
					ar_held <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (aw_fire) begin
			aw_idx <= s_axil_awaddr[axil_addr_w-1:2];
		end
		if (w_fire) begin
			w_data <= s_axil_wdata;
		end
		if (ar_fire) begin
			ar_idx <= s_axil_araddr[axil_addr_w-1:2];
		end

		// Writes win over a read that is pending at the same time
		if (issue) begin
			acc.write <= wr_pending;
			acc.idx <= wr_pending ? aw_idx : ar_idx;
			acc.wdata <= w_data;
		end
	end

endmodule

// ==== hw/regfile_csr.sv ====
`timescale 1ns/100ps

module regfile_csr #(
	parameter bit enable_dep = csr_pkg::enable_dep_default,
	parameter bit enable_counters = csr_pkg::enable_counters_default
) (
	input logic clock,
	input logic reset,

	// Core events
	input logic instr_complete,
	input logic trap,
	input logic tret,
	input logic irq,

	reg_access_if.executor acc,

	// Completed access towards the response channel
	output logic rsp_valid,
	output logic rsp_write,
	output logic [csr_pkg::data_w-1:0] rsp_rdata,
	output logic rsp_err,

	// Architectural state seen by the core
	output logic [csr_pkg::data_w-1:0] mtvec,
	output logic [csr_pkg::data_w-1:0] dep_lo,
	output logic [csr_pkg::data_w-1:0] dep_hi,
	output logic meie,
	output logic mie,
	output logic soft_reset_req
);
	import csr_pkg::*;

	// General registers and CSR backing store
	logic [data_w-1:0] regs [0:(1<<idx_w)-1];

	// 64-bit counters
	logic [2*data_w-1:0] cycle_count;
	logic [2*data_w-1:0] instr_count;

	logic [data_w-1:0] dep_lo_r;
	logic [data_w-1:0] dep_hi_r;
	logic [data_w-1:0] mtvec_r;
	logic mpie;

	logic exec;
	logic wr_en;
	logic ro_hit;

	// Act once per request, the cycle before done goes high
	assign exec = acc.valid && !acc.done;
	assign wr_en = exec && acc.write;
	assign ro_hit = (acc.idx[idx_w-1:idx_w-3] == ro_window);

	assign rsp_valid = acc.done;

	// Pulse for the single cycle the write executes
	assign soft_reset_req = wr_en && (acc.idx == csr_soft_reset);

	// DEP bounds read as zero when protection is built out
	assign dep_lo = enable_dep ? dep_lo_r : '0;
	assign dep_hi = enable_dep ? dep_hi_r : '0;
	assign mtvec = mtvec_r;

	always_ff @(posedge clock) begin
		if (reset) begin
			acc.done <= 1'b0;
			cycle_count <= '0;
			instr_count <= '0;
			dep_lo_r <= '0;
			dep_hi_r <= '0;
			mtvec_r <= '0;
			meie <= 1'b1;
			mie <= 1'b1;
			mpie <= 1'b0;
		end else begin
			acc.done <= exec;

			// A written half replaces the increment for that cycle
			if (enable_counters) begin
				if (wr_en && acc.idx == csr_mcycle) begin
					cycle_count <= {cycle_count[2*data_w-1:data_w], acc.wdata};
				end else if (wr_en && acc.idx == csr_mcycleh) begin
					cycle_count <= {acc.wdata, cycle_count[data_w-1:0]};
				end else begin
					cycle_count <= cycle_count + 1'b1;
				end

				if (wr_en && acc.idx == csr_minstret) begin
					instr_count <= {instr_count[2*data_w-1:data_w], acc.wdata};
				end else if (wr_en && acc.idx == csr_minstreth) begin
					instr_count <= {acc.wdata, instr_count[data_w-1:0]};
				end else if (instr_complete) begin
					instr_count <= instr_count + 1'b1;
				end
			end

			// Trap entry saves the enable, return restores it
			if (trap) begin
				mpie <= mie;
				mie <= 1'b0;
			end
			if (tret) begin
				mie <= mpie;
				mpie <= 1'b0;
			end

			// Host writes land last and win over events
			if (wr_en && acc.idx == csr_mstatus) begin
				mie <= acc.wdata[3];
				mpie <= acc.wdata[7];
			end
			if (wr_en && acc.idx == csr_mie) begin
				meie <= acc.wdata[11];
			end
			if (wr_en && acc.idx == csr_mtvec) begin
				mtvec_r <= acc.wdata;
			end

			// Bit 1 locks a DEP bound until reset
			if (wr_en && acc.idx == csr_dep_lo && !dep_lo_r[1]) begin
				dep_lo_r <= acc.wdata;
			end
			if (wr_en && acc.idx == csr_dep_hi && !dep_hi_r[1]) begin
				dep_hi_r <= acc.wdata;
			end
		end
	end

	always_ff @(posedge clock) begin
		// r0 and the read-only block never take a write
		if (wr_en && acc.idx != '0 && !ro_hit) begin
			regs[acc.idx] <= acc.wdata;
		end

		if (exec) begin
			rsp_write <= acc.write;
			rsp_err <= acc.write && ro_hit;
			case (acc.idx)
				'0: rsp_rdata <= '0;
				csr_mip: rsp_rdata <= data_w'({irq, 11'b0});
				csr_mstatus: rsp_rdata <= data_w'({mpie, 3'b0, mie, 3'b0});
				csr_mie: rsp_rdata <= data_w'({meie, 11'b0});
				csr_mtvec: rsp_rdata <= mtvec_r;
				csr_dep_lo: rsp_rdata <= dep_lo;
				csr_dep_hi: rsp_rdata <= dep_hi;
				csr_mcycle: rsp_rdata <= cycle_count[data_w-1:0];
				csr_mcycleh: rsp_rdata <= cycle_count[2*data_w-1:data_w];
				csr_minstret: rsp_rdata <= instr_count[data_w-1:0];
				csr_minstreth: rsp_rdata <= instr_count[2*data_w-1:data_w];
				default: rsp_rdata <= regs[acc.idx];
			endcase
		end
	end

endmodule

// ==== hw/axil_resp_channel.sv ====
`timescale 1ns/100ps

module axil_resp_channel (
	input logic clock,
	input logic reset,

	// Completed access from the register file
	input logic rsp_valid,
	input logic rsp_write,
	input logic [csr_pkg::data_w-1:0] rsp_rdata,
	input logic rsp_err,

	// Write response channel
	output logic s_axil_bvalid,
	input logic s_axil_bready,
	output logic [1:0] s_axil_bresp,

	// Read data channel
	output logic s_axil_rvalid,
	input logic s_axil_rready,
	output logic [csr_pkg::data_w-1:0] s_axil_rdata,
	output logic [1:0] s_axil_rresp,

	// Buffer empty, front end may take new requests
	output logic idle
);
	import csr_pkg::*;

	assign idle = !s_axil_bvalid && !s_axil_rvalid;

	// Valid flags, cleared only by the matching ready
	always_ff @(posedge clock) begin
		if (reset) begin
			s_axil_bvalid <= 1'b0;
			s_axil_rvalid <= 1'b0;
		end else begin
			if (rsp_valid && rsp_write) begin
				s_axil_bvalid <= 1'b1;
			end else if (s_axil_bready) begin
				s_axil_bvalid <= 1'b0;
			end

			if (rsp_valid && !rsp_write) begin
				s_axil_rvalid <= 1'b1;
			end else if (s_axil_rready) begin
				s_axil_rvalid <= 1'b0;
			end
		end
	end

	// Payload loads only on a new completion, so it stays put under stall
	always_ff @(posedge clock) begin
		if (rsp_valid) begin
			if (rsp_write) begin
				s_axil_bresp <= rsp_err ? resp_slverr : resp_okay;
			end else begin
				s_axil_rdata <= rsp_rdata;
				s_axil_rresp <= rsp_err ? resp_slverr : resp_okay;
			end
		end
	end

endmodule

// ==== hw/regfile_host_top.sv ====
`timescale 1ns/100ps

module regfile_host_top #(
	parameter bit enable_dep = csr_pkg::enable_dep_default
) (
	input logic clock,
	input logic reset,

	// AXI4-Lite slave
	input logic s_axil_awvalid,
	output logic s_axil_awready,
	input logic [csr_pkg::axil_addr_w-1:0] s_axil_awaddr,
	input logic s_axil_wvalid,
	output logic s_axil_wready,
	input logic [csr_pkg::data_w-1:0] s_axil_wdata,
	output logic s_axil_bvalid,
	input logic s_axil_bready,
	output logic [1:0] s_axil_bresp,
	input logic s_axil_arvalid,
	output logic s_axil_arready,
	input logic [csr_pkg::axil_addr_w-1:0] s_axil_araddr,
	output logic s_axil_rvalid,
	input logic s_axil_rready,
	output logic [csr_pkg::data_w-1:0] s_axil_rdata,
	output logic [1:0] s_axil_rresp,

	// Core events
	input logic instr_complete,
	input logic trap,
	input logic tret,
	input logic irq,

	// State towards the core
	output logic [csr_pkg::data_w-1:0] mtvec,
	output logic [csr_pkg::data_w-1:0] dep_lo,
	output logic [csr_pkg::data_w-1:0] dep_hi,
	output logic meie,
	output logic mie,
	output logic soft_reset_req
);
	import csr_pkg::*;

	// Completed access, register file to response buffer
	logic rsp_valid;
	logic rsp_write;
	logic [data_w-1:0] rsp_rdata;
	logic rsp_err;
	logic idle;

	reg_access_if acc_if ();

	axil_reg_frontend frontend_i (
		.clock(clock),
		.reset(reset),
		.s_axil_awvalid(s_axil_awvalid),
		.s_axil_awready(s_axil_awready),
		.s_axil_awaddr(s_axil_awaddr),
		.s_axil_wvalid(s_axil_wvalid),
		.s_axil_wready(s_axil_wready),
		.s_axil_wdata(s_axil_wdata),
		.s_axil_arvalid(s_axil_arvalid),
		.s_axil_arready(s_axil_arready),
		.s_axil_araddr(s_axil_araddr),
		.idle(idle),
		.acc(acc_if.issuer)
	);

	regfile_csr #(
		.enable_dep(enable_dep)
	) regfile_i (
		.clock(clock),
		.reset(reset),
		.instr_complete(instr_complete),
		.trap(trap),
		.tret(tret),
		.irq(irq),
		.acc(acc_if.executor),
		.rsp_valid(rsp_valid),
		.rsp_write(rsp_write),
		.rsp_rdata(rsp_rdata),
		.rsp_err(rsp_err),
		.mtvec(mtvec),
		.dep_lo(dep_lo),
		.dep_hi(dep_hi),
		.meie(meie),
		.mie(mie),
		.soft_reset_req(soft_reset_req)
	);

	axil_resp_channel resp_i (
		.clock(clock),
		.reset(reset),
		.rsp_valid(rsp_valid),
		.rsp_write(rsp_write),
		.rsp_rdata(rsp_rdata),
		.rsp_err(rsp_err),
		.s_axil_bvalid(s_axil_bvalid),
		.s_axil_bready(s_axil_bready),
		.s_axil_bresp(s_axil_bresp),
		.s_axil_rvalid(s_axil_rvalid),
		.s_axil_rready(s_axil_rready),
		.s_axil_rdata(s_axil_rdata),
		.s_axil_rresp(s_axil_rresp),
		.idle(idle)
	);

endmodule

// ==== test/regfile_model.svh ====
`ifndef REGFILE_MODEL_SVH
`define REGFILE_MODEL_SVH

// Expected host-visible state
logic [data_w-1:0] m_regs [0:31];
logic m_mie;
logic m_meie;
logic m_mpie;
logic [data_w-1:0] m_mtvec;
logic [data_w-1:0] m_dep_lo;
logic [data_w-1:0] m_dep_hi;
logic [data_w-1:0] m_instret;

// Values right after reset
function automatic void model_reset();
	m_mie = 1'b1;
	m_meie = 1'b1;
	m_mpie = 1'b0;
	m_mtvec = '0;
	m_dep_lo = '0;
	m_dep_hi = '0;
	m_instret = '0;
endfunction

// Trap entry saves the enable and clears it
function automatic void model_trap();
	m_mpie = m_mie;
	m_mie = 1'b0;
endfunction

function automatic void model_tret();
	m_mie = m_mpie;
	m_mpie = 1'b0;
endfunction

function automatic void model_retire();
	m_instret = m_instret + 1'b1;
endfunction

// Applies one host write, returns the expected response code
function automatic logic [1:0] model_write(input logic [idx_w-1:0] idx,
		input logic [data_w-1:0] data);
	// Read-only block 0x20 to 0x27
	if (idx >= 6'h20 && idx <= 6'h27) begin
		return resp_slverr;
	end
	case (idx)
		csr_mstatus: begin
			m_mie = data[3];
			m_mpie = data[7];
		end
		csr_mie: m_meie = data[11];
		csr_mtvec: m_mtvec = data;
		// Bit 1 of the stored value locks the bound
		csr_dep_lo: begin
			if (!m_dep_lo[1]) begin
				m_dep_lo = data;
			end
		end
		csr_dep_hi: begin
			if (!m_dep_hi[1]) begin
				m_dep_hi = data;
			end
		end
		csr_minstret: m_instret = data;
		default: begin
			if (idx != 0 && idx < 32) begin
				m_regs[idx[4:0]] = data;
			end
		end
	endcase
	return resp_okay;
endfunction

function automatic logic [data_w-1:0] model_read(input logic [idx_w-1:0] idx);
	case (idx)
		6'h00: return '0;
		csr_mip: return data_w'(irq) << 11;
		csr_mstatus: return (data_w'(m_mpie) << 7) | (data_w'(m_mie) << 3);
		csr_mie: return data_w'(m_meie) << 11;
		csr_mtvec: return m_mtvec;
		csr_dep_lo: return m_dep_lo;
		csr_dep_hi: return m_dep_hi;
		csr_minstret: return m_instret;
		default: return m_regs[idx[4:0]];
	endcase
endfunction

// Random stall on the response, payload must hold meanwhile
task automatic hold_response(input bit is_write);
	logic [data_w-1:0] rdata_first;
	logic [1:0] resp_first;
	int stall;
	rdata_first = s_axil_rdata;
	resp_first = is_write ? s_axil_bresp : s_axil_rresp;
	stall = $urandom_range(0, max_stall);
	for (int i = 0; i <= stall; i++) begin
		assert (is_write ? s_axil_bvalid : s_axil_rvalid) else begin
			$display("Response valid dropped before ready was given");
			error_count++;
		end
		check_value(is_write ? "s_axil_bresp" : "s_axil_rresp", resp_first,
			is_write ? s_axil_bresp : s_axil_rresp);
		if (!is_write) begin
			check_value("s_axil_rdata", rdata_first, s_axil_rdata);
		end
		assert (!s_axil_awready && !s_axil_wready && !s_axil_arready) else begin
			$display("A request channel was ready while a response was held");
			error_count++;
		end
		if (i < stall) begin
			@(negedge clock);
		end
	end
	// One cycle of ready takes the response
	s_axil_bready = is_write;
	s_axil_rready = !is_write;
	@(negedge clock);
	s_axil_bready = 1'b0;
	s_axil_rready = 1'b0;
	assert (!s_axil_bvalid && !s_axil_rvalid) else begin
		$display("Response still valid after the ready handshake");
		error_count++;
	end
endtask

// AW and W with independent random skew
task automatic host_write(input logic [idx_w-1:0] idx, input logic [data_w-1:0] data,
		output logic [1:0] resp);
	int aw_delay;
	int w_delay;
	int cycle;
	int waited;
	int pulses_before;
	bit aw_done;
	bit w_done;
	aw_delay = $urandom_range(0, 3);
	w_delay = $urandom_range(0, 3);
	cycle = 0;
	aw_done = 1'b0;
	w_done = 1'b0;
	pulses_before = soft_reset_count;
	while (!(aw_done && w_done)) begin
		@(negedge clock);
		s_axil_awvalid = !aw_done && cycle >= aw_delay;
		s_axil_awaddr = {idx, 2'b00};
		s_axil_wvalid = !w_done && cycle >= w_delay;
		s_axil_wdata = data;
		// Ready is stable here, so this predicts the next rising edge
		aw_done = aw_done || (s_axil_awvalid && s_axil_awready);
		w_done = w_done || (s_axil_wvalid && s_axil_wready);
		cycle++;
	end
	@(negedge clock);
	s_axil_awvalid = 1'b0;
	s_axil_wvalid = 1'b0;
	waited = 0;
	while (!s_axil_bvalid && waited < 50) begin
		@(negedge clock);
		waited++;
	end
	// Capture, execute and response register
	check_value("bvalid latency", 3, waited);
	resp = s_axil_bresp;
	hold_response(1'b1);
	check_value("soft_reset_req pulses", idx == csr_soft_reset,
		soft_reset_count - pulses_before);
endtask

task automatic host_read(input logic [idx_w-1:0] idx, output logic [data_w-1:0] data,
		output logic [1:0] resp);
	int delay;
	int cycle;
	int waited;
	bit ar_done;
	delay = $urandom_range(0, 3);
	cycle = 0;
	ar_done = 1'b0;
	while (!ar_done) begin
		@(negedge clock);
		s_axil_arvalid = cycle >= delay;
		s_axil_araddr = {idx, 2'b00};
		ar_done = s_axil_arvalid && s_axil_arready;
		cycle++;
	end
	@(negedge clock);
	s_axil_arvalid = 1'b0;
	waited = 0;
	while (!s_axil_rvalid && waited < 50) begin
		@(negedge clock);
		waited++;
	end
	check_value("rvalid latency", 3, waited);
	data = s_axil_rdata;
	resp = s_axil_rresp;
	hold_response(1'b0);
endtask

`endif

// ==== test/regfile_host_tb.sv ====
`timescale 1ns/100ps

module regfile_host_tb;
	import csr_pkg::*;

	// Test lengths
	localparam int n_gpr = 80;
	localparam int n_ro = 16;
	localparam int n_mip = 8;
	localparam int n_count = 8;
	localparam int n_trap = 40;
	localparam int n_dep = 30;
	localparam int n_bp = 30;
	localparam int total_txn = 40 + n_gpr + 2 * n_ro + n_mip + 4 * n_count + 2 * n_trap
		+ 3 * n_dep + n_bp;
	// Event pulses fall into the margin
	localparam int watchdog_cycles = total_txn * 40 + 500;

	logic clock;
	logic reset;
	logic s_axil_awvalid;
	logic s_axil_awready;
	logic [axil_addr_w-1:0] s_axil_awaddr;
	logic s_axil_wvalid;
	logic s_axil_wready;
	logic [data_w-1:0] s_axil_wdata;
	logic s_axil_bvalid;
	logic s_axil_bready;
	logic [1:0] s_axil_bresp;
	logic s_axil_arvalid;
	logic s_axil_arready;
	logic [axil_addr_w-1:0] s_axil_araddr;
	logic s_axil_rvalid;
	logic s_axil_rready;
	logic [data_w-1:0] s_axil_rdata;
	logic [1:0] s_axil_rresp;
	logic instr_complete;
	logic trap;
	logic tret;
	logic irq;
	logic [data_w-1:0] mtvec;
	logic [data_w-1:0] dep_lo;
	logic [data_w-1:0] dep_hi;
	logic meie;
	logic mie;
	logic soft_reset_req;

	int error_count = 0;
	int test_count = 0;
	int max_stall = 3;
	int soft_reset_count = 0;

	regfile_host_top dut_i (
		.clock(clock),
		.reset(reset),
		.s_axil_awvalid(s_axil_awvalid),
		.s_axil_awready(s_axil_awready),
		.s_axil_awaddr(s_axil_awaddr),
		.s_axil_wvalid(s_axil_wvalid),
		.s_axil_wready(s_axil_wready),
		.s_axil_wdata(s_axil_wdata),
		.s_axil_bvalid(s_axil_bvalid),
		.s_axil_bready(s_axil_bready),
		.s_axil_bresp(s_axil_bresp),
		.s_axil_arvalid(s_axil_arvalid),
		.s_axil_arready(s_axil_arready),
		.s_axil_araddr(s_axil_araddr),
		.s_axil_rvalid(s_axil_rvalid),
		.s_axil_rready(s_axil_rready),
		.s_axil_rdata(s_axil_rdata),
		.s_axil_rresp(s_axil_rresp),
		.instr_complete(instr_complete),
		.trap(trap),
		.tret(tret),
		.irq(irq),
		.mtvec(mtvec),
		.dep_lo(dep_lo),
		.dep_hi(dep_hi),
		.meie(meie),
		.mie(mie),
		.soft_reset_req(soft_reset_req)
	);

	always #4 clock = ~clock;

	// Soft reset pulses, sampled mid-cycle
	always @(negedge clock) begin
		if (soft_reset_req) begin
			soft_reset_count++;
		end
	end

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		assert (actual === expected) else begin
			$display("Fail %s: expected 0x%0h, got 0x%0h", name, expected, actual);
			error_count++;
		end
	endtask

	`include "regfile_model.svh"

	task automatic write_checked(input logic [idx_w-1:0] idx, input logic [data_w-1:0] data);
		logic [1:0] resp;
		host_write(idx, data, resp);
		check_value("s_axil_bresp", model_write(idx, data), resp);
	endtask

	task automatic read_checked(input logic [idx_w-1:0] idx);
		logic [data_w-1:0] data;
		logic [1:0] resp;
		host_read(idx, data, resp);
		check_value("s_axil_rresp", resp_okay, resp);
		check_value("s_axil_rdata", model_read(idx), data);
	endtask

	task automatic pulse_event(input bit is_trap);
		@(negedge clock);
		trap = is_trap;
		tret = !is_trap;
		if (is_trap) begin
			model_trap();
		end else begin
			model_tret();
		end
		@(negedge clock);
		trap = 1'b0;
		tret = 1'b0;
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		$display("Test %0d %s: %s", test_count, name,
			(error_count == errors_before) ? "passed" : "failed");
	endtask

	task automatic run_reset_test();
		int errors_before;
		errors_before = error_count;
		check_value("s_axil_bvalid", 0, s_axil_bvalid);
		check_value("s_axil_rvalid", 0, s_axil_rvalid);
		check_value("soft_reset_req", 0, soft_reset_req);
		check_value("meie", 1, meie);
		check_value("mie", 1, mie);
		check_value("mtvec", 0, mtvec);
		check_value("dep_lo", 0, dep_lo);
		check_value("dep_hi", 0, dep_hi);
		// mpie and the retired count start at zero
		read_checked(csr_mstatus);
		read_checked(csr_minstret);
		report_test("reset state", errors_before);
	endtask

	task automatic run_gpr_test();
		int errors_before;
		logic [idx_w-1:0] idx;
		errors_before = error_count;
		for (int i = 1; i < 32; i++) begin
			write_checked(idx_w'(i), $urandom());
		end
		repeat (n_gpr) begin
			idx = $urandom_range(1, 31);
			if ($urandom_range(0, 1)) begin
				write_checked(idx, $urandom());
			end else begin
				read_checked(idx);
			end
		end
		// r0 stays zero
		write_checked(6'h00, $urandom());
		read_checked(6'h00);
		report_test("general registers", errors_before);
	endtask

	task automatic run_ro_test();
		int errors_before;
		logic [idx_w-1:0] idx;
		logic [data_w-1:0] data;
		logic [data_w-1:0] rdata;
		logic [1:0] resp;
		errors_before = error_count;
		repeat (n_ro) begin
			idx = 6'h20 + idx_w'($urandom_range(0, 7));
			data = $urandom();
			write_checked(idx, data);
			host_read(idx, rdata, resp);
			check_value("s_axil_rresp", resp_okay, resp);
			if (idx == csr_mip) begin
				check_value("s_axil_rdata", model_read(idx), rdata);
			end else begin
				assert (rdata !== data) else begin
					$display("Read-only index 0x%0h took the rejected write data", idx);
					error_count++;
				end
			end
		end
		// irq only changes between accesses
		repeat (n_mip) begin
			irq = $urandom_range(0, 1);
			read_checked(csr_mip);
		end
		irq = 1'b0;
		report_test("read-only window", errors_before);
	endtask

	task automatic run_counter_test();
		int errors_before;
		int pulses;
		logic [data_w-1:0] start;
		logic [data_w-1:0] rdata;
		logic [1:0] resp;
		errors_before = error_count;
		repeat (n_count) begin
			write_checked(csr_minstret, $urandom());
			pulses = $urandom_range(1, 20);
			repeat (pulses) begin
				@(negedge clock);
				instr_complete = 1'b1;
				model_retire();
				@(negedge clock);
				instr_complete = 1'b0;
			end
			read_checked(csr_minstret);
			// Cycle counter keeps running, so only a range is known
			start = $urandom_range(0, 32'h7fff_ffff);
			write_checked(csr_mcycle, start);
			host_read(csr_mcycle, rdata, resp);
			assert (rdata >= start && rdata <= start + data_w'(watchdog_cycles)) else begin
				$display("Fail mcycle: expected 0x%0h to 0x%0h, got 0x%0h", start,
					start + data_w'(watchdog_cycles), rdata);
				error_count++;
			end
		end
		report_test("counters", errors_before);
	endtask

	task automatic run_trap_test();
		int errors_before;
		errors_before = error_count;
		repeat (n_trap) begin
			case ($urandom_range(0, 3))
				0: pulse_event(1'b1);
				1: pulse_event(1'b0);
				2: write_checked(csr_mstatus, $urandom());
				default: write_checked(csr_mie, $urandom());
			endcase
			check_value("mie", m_mie, mie);
			check_value("meie", m_meie, meie);
			if ($urandom_range(0, 3) == 0) begin
				read_checked($urandom_range(0, 1) ? csr_mstatus : csr_mie);
			end
		end
		report_test("trap state", errors_before);
	endtask

	task automatic run_dep_test();
		int errors_before;
		logic [data_w-1:0] data;
		errors_before = error_count;
		for (int i = 0; i < n_dep; i++) begin
			data = $urandom();
			// Lock late, so the unlocked phase gets exercised too
			if (i < n_dep / 2 || $urandom_range(0, 3) != 0) begin
				data[1] = 1'b0;
			end
			if (i == n_dep - 6) begin
				data[1] = 1'b1;
			end
			write_checked($urandom_range(0, 1) ? csr_dep_hi : csr_dep_lo, data);
			if (i == n_dep - 5) begin
				write_checked(csr_dep_lo, $urandom() | 32'h2);
				write_checked(csr_dep_hi, $urandom() | 32'h2);
			end
			check_value("dep_lo", m_dep_lo, dep_lo);
			check_value("dep_hi", m_dep_hi, dep_hi);
			write_checked(csr_mtvec, $urandom());
			check_value("mtvec", m_mtvec, mtvec);
			if (i % 6 == 0) begin
				write_checked(csr_soft_reset, $urandom());
			end
		end
		read_checked(csr_dep_lo);
		read_checked(csr_dep_hi);
		read_checked(csr_mtvec);
		report_test("protection, vector and soft reset", errors_before);
	endtask

	task automatic run_backpressure_test();
		int errors_before;
		logic [idx_w-1:0] idx;
		errors_before = error_count;
		max_stall = 25;
		repeat (n_bp) begin
			idx = $urandom_range(1, 31);
			if ($urandom_range(0, 1)) begin
				write_checked(idx, $urandom());
			end else begin
				read_checked(idx);
			end
		end
		max_stall = 3;
		report_test("back-pressure", errors_before);
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		s_axil_awvalid = 1'b0;
		s_axil_awaddr = '0;
		s_axil_wvalid = 1'b0;
		s_axil_wdata = '0;
		s_axil_bready = 1'b0;
		s_axil_arvalid = 1'b0;
		s_axil_araddr = '0;
		s_axil_rready = 1'b0;
		instr_complete = 1'b0;
		trap = 1'b0;
		tret = 1'b0;
		irq = 1'b0;
		void'($urandom(19262));
		model_reset();
		repeat (4) @(negedge clock);
		reset = 1'b0;
		run_reset_test();
		run_gpr_test();
		run_ro_test();
		run_counter_test();
		run_trap_test();
		run_dep_test();
		run_backpressure_test();
		$display("%0d tests run, %0d errors", test_count, error_count);
		if (error_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// Watchdog sized from the test lengths
	initial begin
		#(watchdog_cycles * 8);
		$display("Watchdog expired after %0d cycles before the tests completed",
			watchdog_cycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== regfile_host.f ====
+incdir+test
hw/csr_pkg.sv
hw/reg_access_if.sv
hw/axil_reg_frontend.sv
hw/regfile_csr.sv
hw/axil_resp_channel.sv
hw/regfile_host_top.sv
test/regfile_host_tb.sv

// ==== Bender.yml ====
package:
  name: regfile_host

sources:
  - hw/csr_pkg.sv
  - hw/reg_access_if.sv
  - hw/axil_reg_frontend.sv
  - hw/regfile_csr.sv
  - hw/axil_resp_channel.sv
  - hw/regfile_host_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/regfile_host_tb.sv
